// File: rtl/md_consts.svh
`ifndef MD_CONSTS_SVH
`define MD_CONSTS_SVH

// operand and result word width.
`define MD_WIDTH        32

// multiplier bits consumed in each multiply step.
`define MD_MUL_BITS     8
`define MD_MUL_STEPS    4
`define MD_MUL_CNT_W    2

// one quotient bit per divide step.
`define MD_DIV_STEPS    32
`define MD_DIV_CNT_W    5

// pipeline stall vector.
`define MD_STALL_W      6
`define MD_STALL_EX     2

`endif

// File: rtl/md_pkg.sv
`default_nettype none

`include "md_consts.svh"

package md_pkg;

    typedef enum logic [2:0] {
        MD_NONE   = 3'd0,
        MD_MUL_LO = 3'd1,
        MD_MUL_HI = 3'd2,
        MD_DIV    = 3'd3,
        MD_REM    = 3'd4
    } md_op_e;

    typedef enum logic [1:0] {
        LOCK_IDLE = 2'd0,
        LOCK_BUSY = 2'd1,
        LOCK_DONE = 2'd2
    } md_lock_state_e;

    // operand magnitudes plus the sign fix-up needed at the end.
    typedef struct packed {
        logic [`MD_WIDTH-1:0] mag_a;
        logic [`MD_WIDTH-1:0] mag_b;
        md_op_e               op;
        logic                 neg_res;
        logic                 neg_rem;
    } md_operands_t;

    // product as hi/lo, or remainder in hi and quotient in lo.
    typedef struct packed {
        logic [`MD_WIDTH-1:0] hi;
        logic [`MD_WIDTH-1:0] lo;
    } md_raw_t;

endpackage

`default_nettype wire

// File: rtl/md_operand_lock.sv
`timescale 1ns/1ps
`default_nettype none

`include "md_consts.svh"

module md_operand_lock (
    input  logic                     clk,
    input  logic                     rst_n,
    input  md_pkg::md_op_e           op,
    input  logic                     is_signed,
    input  logic [`MD_WIDTH-1:0]     a,
    input  logic [`MD_WIDTH-1:0]     b,
    input  logic [`MD_STALL_W-1:0]   stall,
    input  logic                     mul_done,
    input  logic                     div_done,
    output md_pkg::md_operands_t     locked,
    output logic                     mul_start,
    output logic                     div_start,
    output logic                     done,
    output logic                     stallreq
);

    md_pkg::md_lock_state_e state_q;
    md_pkg::md_operands_t   locked_q;
    logic                   mul_start_q;
    logic                   div_start_q;
    logic                   op_is_mul;
    logic                   op_is_div;
    logic                   locked_is_mul;
    logic                   neg_a;
    logic                   neg_b;
    logic                   unit_done;
    md_pkg::md_operands_t   capture;

    assign op_is_mul = (op == md_pkg::MD_MUL_LO) || (op == md_pkg::MD_MUL_HI);
    assign op_is_div = (op == md_pkg::MD_DIV) || (op == md_pkg::MD_REM);

    assign neg_a = is_signed & a[`MD_WIDTH-1];
    assign neg_b = is_signed & b[`MD_WIDTH-1];

    // magnitudes and sign flags of the incoming instruction.
    always_comb begin
        capture.mag_a   = neg_a ? (~a + 1'b1) : a;
        capture.mag_b   = neg_b ? (~b + 1'b1) : b;
        capture.op      = op;
        capture.neg_res = (neg_a ^ neg_b) & ~(op_is_div & (b == '0));
        capture.neg_rem = neg_a;
    end

    assign locked_is_mul = (locked_q.op == md_pkg::MD_MUL_LO) ||
                           (locked_q.op == md_pkg::MD_MUL_HI);
    assign unit_done     = locked_is_mul ? mul_done : div_done;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q     <= md_pkg::LOCK_IDLE;
            mul_start_q <= 1'b0;
            div_start_q <= 1'b0;
        end else begin
            mul_start_q <= 1'b0;
            div_start_q <= 1'b0;
            case (state_q)
                md_pkg::LOCK_IDLE: begin
                    if (op_is_mul || op_is_div) begin
                        state_q     <= md_pkg::LOCK_BUSY;
                        mul_start_q <= op_is_mul;
                        div_start_q <= op_is_div;
                    end
                end
                md_pkg::LOCK_BUSY: begin
                    if (unit_done) begin
                        state_q <= md_pkg::LOCK_DONE;
                    end
                end
                md_pkg::LOCK_DONE: begin
                    // hold until the instruction leaves execute.
                    if (!stall[`MD_STALL_EX]) begin
                        state_q <= md_pkg::LOCK_IDLE;
                    end
                end
                default: state_q <= md_pkg::LOCK_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == md_pkg::LOCK_IDLE && (op_is_mul || op_is_div)) begin
            locked_q <= capture;
        end
    end

    assign locked    = locked_q;
    assign mul_start = mul_start_q;
    assign div_start = div_start_q;
    assign done      = (state_q == md_pkg::LOCK_DONE);
    assign stallreq  = (op != md_pkg::MD_NONE) && (state_q != md_pkg::LOCK_DONE);

endmodule

`default_nettype wire

// File: rtl/md_multiplier.sv
`timescale 1ns/1ps
`default_nettype none

`include "md_consts.svh"

module md_multiplier (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  logic [`MD_WIDTH-1:0] mag_a,
    input  logic [`MD_WIDTH-1:0] mag_b,
    output logic                 done,
    output md_pkg::md_raw_t      prod
);

    logic [2*`MD_WIDTH-1:0]   acc_q;
    logic [2*`MD_WIDTH-1:0]   a_sh_q;
    logic [`MD_WIDTH-1:0]     b_sh_q;
    logic [`MD_MUL_CNT_W-1:0] cnt_q;
    logic                     busy_q;

    logic [2*`MD_WIDTH-1:0]   acc_in;
    logic [2*`MD_WIDTH-1:0]   a_in;
    logic [`MD_WIDTH-1:0]     b_in;
    logic [2*`MD_WIDTH-1:0]   partial;
    logic [2*`MD_WIDTH-1:0]   acc_next;

    // the start cycle already performs the first step on the fresh operands.
    assign acc_in = start ? '0 : acc_q;
    assign a_in   = start ? {{`MD_WIDTH{1'b0}}, mag_a} : a_sh_q;
    assign b_in   = start ? mag_b : b_sh_q;

    assign partial  = a_in * {{(2*`MD_WIDTH-`MD_MUL_BITS){1'b0}}, b_in[`MD_MUL_BITS-1:0]};
    assign acc_next = acc_in + partial;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (start) begin
            busy_q <= 1'b1;
            cnt_q  <= `MD_MUL_CNT_W'(1);
        end else if (busy_q) begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == `MD_MUL_CNT_W'(`MD_MUL_STEPS - 1)) begin
                busy_q <= 1'b0;
            end
        end
    end

    // product stays put once the unit goes idle.
    always_ff @(posedge clk) begin
        if (start || busy_q) begin
            acc_q  <= acc_next;
            a_sh_q <= a_in << `MD_MUL_BITS;
            b_sh_q <= b_in >> `MD_MUL_BITS;
        end
    end

    // high during the cycle that takes the last slice.
    assign done = busy_q && (cnt_q == `MD_MUL_CNT_W'(`MD_MUL_STEPS - 1));

    assign prod.hi = acc_q[2*`MD_WIDTH-1:`MD_WIDTH];
    assign prod.lo = acc_q[`MD_WIDTH-1:0];

endmodule

`default_nettype wire

// File: rtl/md_divider.sv
`timescale 1ns/1ps
`default_nettype none

`include "md_consts.svh"

module md_divider (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start,
    input  logic [`MD_WIDTH-1:0] mag_a,
    input  logic [`MD_WIDTH-1:0] mag_b,
    output logic                 done,
    output md_pkg::md_raw_t      quo_rem
);

    logic [`MD_WIDTH-1:0]     rem_q;
    logic [`MD_WIDTH-1:0]     dq_q;
    logic [`MD_WIDTH-1:0]     dvs_q;
    logic [`MD_DIV_CNT_W-1:0] cnt_q;
    logic                     busy_q;

    logic [`MD_WIDTH-1:0]     rem_in;
    logic [`MD_WIDTH-1:0]     dq_in;
    logic [`MD_WIDTH-1:0]     dvs_in;
    logic [`MD_WIDTH:0]       trial;
    logic [`MD_WIDTH:0]       diff;
    logic                     q_bit;

    assign rem_in = start ? '0 : rem_q;
    assign dq_in  = start ? mag_a : dq_q;
    assign dvs_in = start ? mag_b : dvs_q;

    // shift in the next dividend bit and try the subtraction.
    assign trial = {rem_in, dq_in[`MD_WIDTH-1]};
    assign diff  = trial - {1'b0, dvs_in};
    assign q_bit = ~diff[`MD_WIDTH];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (start) begin
            busy_q <= 1'b1;
            cnt_q  <= `MD_DIV_CNT_W'(1);
        end else if (busy_q) begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == `MD_DIV_CNT_W'(`MD_DIV_STEPS - 1)) begin
                busy_q <= 1'b0;
            end
        end
    end

    // the dividend register fills with quotient bits from the bottom.
    always_ff @(posedge clk) begin
        if (start || busy_q) begin
            rem_q <= q_bit ? diff[`MD_WIDTH-1:0] : trial[`MD_WIDTH-1:0];
            dq_q  <= {dq_in[`MD_WIDTH-2:0], q_bit};
            dvs_q <= dvs_in;
        end
    end

    assign done = busy_q && (cnt_q == `MD_DIV_CNT_W'(`MD_DIV_STEPS - 1));

    assign quo_rem.hi = rem_q;
    assign quo_rem.lo = dq_q;

endmodule

`default_nettype wire

// File: rtl/md_result_fix.sv
`timescale 1ns/1ps
`default_nettype none

`include "md_consts.svh"

module md_result_fix (
    input  md_pkg::md_operands_t locked,
    input  logic                 done,
    input  md_pkg::md_raw_t      prod,
    input  md_pkg::md_raw_t      quo_rem,
    output logic [`MD_WIDTH-1:0] result
);

    logic [2*`MD_WIDTH-1:0] prod_raw;
    logic [2*`MD_WIDTH-1:0] prod_fix;
    logic [`MD_WIDTH-1:0]   quo_fix;
    logic [`MD_WIDTH-1:0]   rem_fix;

    // negate all 64 bits so the borrow reaches the high word.
    assign prod_raw = {prod.hi, prod.lo};
    assign prod_fix = locked.neg_res ? (~prod_raw + 1'b1) : prod_raw;

    assign quo_fix = locked.neg_res ? (~quo_rem.lo + 1'b1) : quo_rem.lo;
    assign rem_fix = locked.neg_rem ? (~quo_rem.hi + 1'b1) : quo_rem.hi;

    always_comb begin
        result = '0;
        if (done) begin
            case (locked.op)
                md_pkg::MD_MUL_LO: result = prod_fix[`MD_WIDTH-1:0];
                md_pkg::MD_MUL_HI: result = prod_fix[2*`MD_WIDTH-1:`MD_WIDTH];
                md_pkg::MD_DIV:    result = quo_fix;
                md_pkg::MD_REM:    result = rem_fix;
                default:           result = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: rtl/mul_div_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "md_consts.svh"

module mul_div_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  md_pkg::md_op_e         op,
    input  logic                   is_signed,
    input  logic [`MD_WIDTH-1:0]   a,
    input  logic [`MD_WIDTH-1:0]   b,
    input  logic [`MD_STALL_W-1:0] stall,
    output logic                   stallreq,
    output logic [`MD_WIDTH-1:0]   result
);

    md_pkg::md_operands_t locked;
    md_pkg::md_raw_t      prod;
    md_pkg::md_raw_t      quo_rem;
    logic                 mul_start;
    logic                 div_start;
    logic                 mul_done;
    logic                 div_done;
    logic                 done;

    md_operand_lock u_lock (
        .clk       (clk),
        .rst_n     (rst_n),
        .op        (op),
        .is_signed (is_signed),
        .a         (a),
        .b         (b),
        .stall     (stall),
        .mul_done  (mul_done),
        .div_done  (div_done),
        .locked    (locked),
        .mul_start (mul_start),
        .div_start (div_start),
        .done      (done),
        .stallreq  (stallreq)
    );

    md_multiplier u_mul (
        .clk   (clk),
        .rst_n (rst_n),
        .start (mul_start),
        .mag_a (locked.mag_a),
        .mag_b (locked.mag_b),
        .done  (mul_done),
        .prod  (prod)
    );

    md_divider u_div (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (div_start),
        .mag_a   (locked.mag_a),
        .mag_b   (locked.mag_b),
        .done    (div_done),
        .quo_rem (quo_rem)
    );

    md_result_fix u_fix (
        .locked  (locked),
        .done    (done),
        .prod    (prod),
        .quo_rem (quo_rem),
        .result  (result)
    );

endmodule

`default_nettype wire

// File: tb/tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD_NS = 4
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2);
            clk = ~clk;
        end
    end

endmodule

`default_nettype wire

// File: tb/mul_div_chk.sv
`timescale 1ns/1ps
`default_nettype none

`include "md_consts.svh"

module mul_div_chk (
    input logic                   clk,
    input logic                   rst_n,
    input md_pkg::md_lock_state_e state,
    input logic [`MD_STALL_W-1:0] stall,
    input logic                   stallreq,
    input logic                   mul_start,
    input logic                   div_start,
    input logic                   mul_done,
    input logic                   div_done
);

    // the pipeline is released as soon as the result is there.
    a_release_on_done: assert property (@(posedge clk) disable iff (!rst_n)
        (state == md_pkg::LOCK_BUSY && (mul_done || div_done)) |=>
            (state == md_pkg::LOCK_DONE && !stallreq))
        else $error("stall request still high after the unit finished");

    a_mul_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        mul_start |=> !mul_start)
        else $error("multiplier start longer than one cycle");

    a_div_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        div_start |=> !div_start)
        else $error("divider start longer than one cycle");

    // result must stay while execute is stalled.
    a_hold_done: assert property (@(posedge clk) disable iff (!rst_n)
        (state == md_pkg::LOCK_DONE && stall[`MD_STALL_EX]) |=> state == md_pkg::LOCK_DONE)
        else $error("lock left the done state while execute was stalled");

endmodule

`default_nettype wire

// File: tb/mul_div_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "md_consts.svh"

module mul_div_tb;

    localparam int W           = `MD_WIDTH;
    localparam int CLK_NS      = 4;
    localparam int HOLD_MAX    = 6;
    localparam int MUL_OPS     = 140;
    localparam int DIV_OPS     = 100;
    localparam int MUL_CYCLES  = `MD_MUL_STEPS + 3 + HOLD_MAX;
    localparam int DIV_CYCLES  = `MD_DIV_STEPS + 3 + HOLD_MAX;
    localparam int WATCHDOG_NS = 2 * (MUL_OPS * MUL_CYCLES + DIV_OPS * DIV_CYCLES + 10) * CLK_NS;
    localparam int STALL_LIMIT = 2 * (`MD_DIV_STEPS + 1);

    logic                   clk;
    logic                   rst_n;
    md_pkg::md_op_e         op;
    logic                   is_signed;
    logic [W-1:0]           a;
    logic [W-1:0]           b;
    logic [`MD_STALL_W-1:0] stall;
    logic                   stallreq;
    logic [W-1:0]           result;
    int                     value_errors;
    int                     protocol_errors;
    logic [31:0]            lfsr_q;

    tb_clkgen #(.PERIOD_NS(CLK_NS)) u_clk (.clk(clk));

    mul_div_top UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .op        (op),
        .is_signed (is_signed),
        .a         (a),
        .b         (b),
        .stall     (stall),
        .stallreq  (stallreq),
        .result    (result)
    );

    bind md_operand_lock mul_div_chk u_chk (
        .clk       (clk),
        .rst_n     (rst_n),
        .state     (state_q),
        .stall     (stall),
        .stallreq  (stallreq),
        .mul_start (mul_start),
        .div_start (div_start),
        .mul_done  (mul_done),
        .div_done  (div_done)
    );

    // taps for x^32 + x^22 + x^2 + x + 1.
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic rand_word(output logic [W-1:0] w);
        w = '0;
        for (int i = 0; i < W; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            w = {w[W-2:0], lfsr_q[0]};
        end
    endtask

    // exact 64-bit arithmetic on sign- or zero-extended operands.
    function automatic logic [W-1:0] model_result(input md_pkg::md_op_e op_in, input logic sgn,
                                                  input logic [W-1:0] x, input logic [W-1:0] y);
        logic signed [2*W-1:0] ext_x;
        logic signed [2*W-1:0] ext_y;
        logic signed [2*W-1:0] prod;
        logic signed [2*W-1:0] quo;
        logic signed [2*W-1:0] rem;
        ext_x = sgn ? {{W{x[W-1]}}, x} : {{W{1'b0}}, x};
        ext_y = sgn ? {{W{y[W-1]}}, y} : {{W{1'b0}}, y};
        prod  = ext_x * ext_y;
        if (y == '0) begin
            quo = '1;
            rem = ext_x;
        end else begin
            quo = ext_x / ext_y;
            rem = ext_x % ext_y;
        end
        case (op_in)
            md_pkg::MD_MUL_LO: return prod[W-1:0];
            md_pkg::MD_MUL_HI: return prod[2*W-1:W];
            md_pkg::MD_DIV:    return quo[W-1:0];
            md_pkg::MD_REM:    return rem[W-1:0];
            default:           return '0;
        endcase
    endfunction

    task automatic compare_word(input string name, input logic [W-1:0] exp,
                                input logic [W-1:0] act);
        if (act !== exp) begin
            value_errors++;
            $display("** Error: %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic compare_count(input string name, input int exp, input int act);
        if (act != exp) begin
            value_errors++;
            $display("** Error: %s expected %0d stall cycles actual %0d", name, exp, act);
        end
    endtask

    task automatic compare_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            value_errors++;
            $display("** Error: %s expected stallreq %b actual %b", name, exp, act);
        end
    endtask

    // issue one instruction, count its stall cycles, then hold it in execute.
    task automatic issue_op(input string name, input md_pkg::md_op_e op_in, input logic sgn,
                            input logic [W-1:0] x, input logic [W-1:0] y, input int hold);
        logic [W-1:0] expected;
        int           cycles;
        int           exp_cycles;
        expected   = model_result(op_in, sgn, x, y);
        exp_cycles = (op_in == md_pkg::MD_MUL_LO || op_in == md_pkg::MD_MUL_HI) ?
                     `MD_MUL_STEPS + 1 : `MD_DIV_STEPS + 1;
        cycles     = 0;
        @(negedge clk);
        op        = op_in;
        is_signed = sgn;
        a         = x;
        b         = y;
        stall     = (hold > 0) ? (`MD_STALL_W'(1) << `MD_STALL_EX) : '0;
        #1;
        while (stallreq && cycles < STALL_LIMIT) begin
            cycles++;
            @(negedge clk);
            #1;
        end
        if (stallreq) begin
            protocol_errors++;
            $display("%s: stall request never dropped after %0d cycles", name, cycles);
        end
        compare_count(name, exp_cycles, cycles);
        compare_word(name, expected, result);
        repeat (hold) begin
            @(negedge clk);
            #1;
            compare_word(name, expected, result);
            compare_flag(name, 1'b0, stallreq);
        end
        @(negedge clk);
        op    = md_pkg::MD_NONE;
        stall = '0;
    endtask

    task automatic mul_lo_hi(input string name, input logic sgn,
                             input logic [W-1:0] x, input logic [W-1:0] y);
        issue_op(name, md_pkg::MD_MUL_LO, sgn, x, y, 0);
        issue_op(name, md_pkg::MD_MUL_HI, sgn, x, y, 0);
    endtask

    task automatic div_quo_rem(input string name, input logic sgn,
                               input logic [W-1:0] x, input logic [W-1:0] y);
        issue_op(name, md_pkg::MD_DIV, sgn, x, y, 0);
        issue_op(name, md_pkg::MD_REM, sgn, x, y, 0);
    endtask

    task automatic idle_after_reset();
        @(negedge clk);
        #1;
        compare_flag("reset_state", 1'b0, stallreq);
        compare_word("reset_state", '0, result);
    endtask

    task automatic unsigned_multiplies();
        logic [W-1:0] x;
        logic [W-1:0] y;
        mul_lo_hi("mul_unsigned", 1'b0, 32'h0000_0000, 32'h0000_0000);
        mul_lo_hi("mul_unsigned", 1'b0, 32'hffff_ffff, 32'hffff_ffff);
        mul_lo_hi("mul_unsigned", 1'b0, 32'h0000_0001, 32'hffff_ffff);
        mul_lo_hi("mul_unsigned", 1'b0, 32'h8000_0000, 32'h0000_0002);
        mul_lo_hi("mul_unsigned", 1'b0, 32'hdead_beef, 32'h1234_5678);
        mul_lo_hi("mul_unsigned", 1'b0, 32'hffff_ffff, 32'h0000_0000);
        repeat (40) begin
            rand_word(x);
            rand_word(y);
            mul_lo_hi("mul_unsigned", 1'b0, x, y);
        end
    endtask

    task automatic signed_multiplies();
        logic [W-1:0] x;
        logic [W-1:0] y;
        mul_lo_hi("mul_signed", 1'b1, 32'hffff_fffe, 32'h0000_0003);
        // the magnitude product is 2^32 so the negated high word needs the borrow.
        mul_lo_hi("mul_signed", 1'b1, 32'h0001_0000, 32'hffff_0000);
        mul_lo_hi("mul_signed", 1'b1, 32'h7fff_ffff, 32'h8000_0000);
        mul_lo_hi("mul_signed", 1'b1, 32'h8000_0000, 32'h8000_0000);
        mul_lo_hi("mul_signed", 1'b1, 32'hffff_fffb, 32'hffff_fff9);
        mul_lo_hi("mul_signed", 1'b1, 32'h0000_0001, 32'hffff_ffff);
        repeat (12) begin
            rand_word(x);
            rand_word(y);
            mul_lo_hi("mul_signed", 1'b1, x, y);
        end
    endtask

    task automatic random_divides();
        logic [W-1:0] x;
        logic [W-1:0] y;
        logic         neg_y;
        repeat (20) begin
            rand_word(x);
            rand_word(y);
            neg_y = y[W-1];
            // spread divisor sizes so quotients are not always tiny.
            y = y >> y[4:0];
            // keep negative divisors in the mix.
            if (neg_y) begin
                y = ~y + 1'b1;
            end
            div_quo_rem("div_random", 1'b0, x, y);
            div_quo_rem("div_random", 1'b1, x, y);
        end
    endtask

    task automatic divide_corners();
        div_quo_rem("div_by_zero", 1'b0, 32'h1234_5678, 32'h0000_0000);
        div_quo_rem("div_by_zero", 1'b1, 32'hffff_fff0, 32'h0000_0000);
        div_quo_rem("div_overflow", 1'b1, 32'h8000_0000, 32'hffff_ffff);
    endtask

    task automatic execute_backpressure();
        issue_op("backpressure", md_pkg::MD_MUL_HI, 1'b1, 32'hffff_fffe, 32'h0000_0003, 4);
        issue_op("backpressure", md_pkg::MD_DIV, 1'b1, 32'hffff_ff9c, 32'h0000_0007, HOLD_MAX);
        issue_op("backpressure", md_pkg::MD_REM, 1'b0, 32'h0000_0064, 32'h0000_0007, 0);
        @(negedge clk);
        #1;
        compare_word("backpressure", '0, result);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns", WATCHDOG_NS);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        lfsr_q          = 32'hfed4;
        value_errors    = 0;
        protocol_errors = 0;
        rst_n           = 1'b0;
        op              = md_pkg::MD_NONE;
        is_signed       = 1'b0;
        a               = '0;
        b               = '0;
        stall           = '0;
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
        idle_after_reset();
        unsigned_multiplies();
        signed_multiplies();
        random_divides();
        divide_corners();
        execute_backpressure();
        $display("errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+rtl
rtl/md_pkg.sv
rtl/md_operand_lock.sv
rtl/md_multiplier.sv
rtl/md_divider.sv
rtl/md_result_fix.sv
rtl/mul_div_top.sv
tb/tb_clkgen.sv
tb/mul_div_chk.sv
tb/mul_div_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= mul_div_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(wildcard rtl/*.sv rtl/*.svh tb/*.sv)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@grep -q "^Simulation finished: PASS$$" $(LOG) || (echo "run did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
